//--- hw/chanPkg.sv
// Shared widths and word formats of one APV channel back end
// Output word tag sits in the top two bits of every stored word
package chanPkg;

	localparam int dataWidth = 12;
	localparam int frameWidth = 13;
	localparam int stripCount = 128;
	localparam int stripAddrWidth = 7;
	localparam int wordWidth = 21;
	localparam int wordCountWidth = 8;
	localparam int countWidth = 5;
	localparam int defaultFifoAddrWidth = 11;

	localparam logic [1:0] tagHeader = 2'b00;
	localparam logic [1:0] tagStrip = 2'b01;
	localparam logic [1:0] tagModuleTrailer = 2'b10;
	localparam logic [1:0] tagCountTrailer = 2'b11;

	typedef struct packed {
		logic [1:0] tag;
		logic reserved;
		logic meanSign;
		logic [frameWidth-1:0] frameHeader;
		logic [3:0] channel;
	} headerWord;

	typedef struct packed {
		logic [1:0] tag;
		logic [stripAddrWidth-1:0] addr;
		logic [dataWidth-1:0] value;
	} stripWord;

	typedef struct packed {
		logic [1:0] tag;
		logic [1:0] zero;
		logic [4:0] modId;
		logic [dataWidth-1:0] trailer;
	} modTrailerWord;

	typedef struct packed {
		logic [1:0] tag;
		logic [dataWidth-2:0] meanLow;
		logic [wordCountWidth-1:0] wordCount;
	} countTrailerWord;

	typedef union packed {
		headerWord header;
		stripWord strip;
		modTrailerWord moduleTrailer;
		countTrailerWord countTrailer;
	} outWord;

	typedef enum logic [2:0] {
		cutIdle,
		cutAddr,
		cutCompare,
		cutTrailerWait,
		cutModuleTrailer,
		cutCountTrailer,
		cutDone
	} cutState;

endpackage

//--- hw/frameIf.sv
// Decoded frame stream plus baseline, popped by single-cycle pulses
`timescale 1ns/1ps

interface frameIf
	import chanPkg::*;
();
	logic [frameWidth-1:0] frameData;
	logic frameReady;
	logic frameRd;
	logic [dataWidth-1:0] mean;
	logic meanRd;

	modport source (output frameData, output frameReady, output mean,
		input frameRd, input meanRd);

	modport cut (input frameData, input frameReady, input mean,
		output frameRd, output meanRd);

endinterface

//--- hw/thresholdRam.sv
// No reset on the array, every entry must be loaded by the host before use
// Read data is registered and shows the old value on a same-address write
`timescale 1ns/1ps

module thresholdRam
	import chanPkg::*;
(
	input logic CLK,
	input logic we,
	input logic [stripAddrWidth-1:0] wrAddr,
	input logic [dataWidth-1:0] wrData,
	input logic [stripAddrWidth-1:0] rdAddr,
	output logic [dataWidth-1:0] rdData
);

	logic [dataWidth-1:0] mem [stripCount];

	always_ff @(posedge CLK)
	begin
		if (we)
			mem[wrAddr] <= wrData;
		rdData <= mem[rdAddr];
	end

endmodule

//--- hw/zeroSuppressor.sv
// Two cycles per strip; expects a full frame waiting when frameReady is high
// No back-pressure from the output FIFO
`timescale 1ns/1ps

module zeroSuppressor
	import chanPkg::*;
(
	input logic CLK,
	input logic RSTb,
	input logic clear,
	input logic enableBaseSub,
	input logic [3:0] chId,
	input logic [4:0] moduleId,
	frameIf.cut fr,
	output logic [stripAddrWidth-1:0] stripAddr,
	input logic [dataWidth-1:0] threshold,
	output logic wrEn,
	output outWord wrData
);

	localparam logic [stripAddrWidth-1:0] lastStrip = stripAddrWidth'(stripCount - 1);

	cutState state;
	logic [wordCountWidth-1:0] wordCount;
	logic [dataWidth-1:0] usedMean;
	logic [frameWidth-1:0] diff;
	logic keep;

	assign usedMean = enableBaseSub ? fr.mean : '0;
	// Wraps modulo 2^13 like the subtractor it replaces
	assign diff = fr.frameData - {1'b0, usedMean};
	// All-ones threshold disables the strip
	assign keep = (threshold != '1) && (diff > {1'b0, threshold});

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			state <= cutIdle;
			stripAddr <= '0;
			wordCount <= '0;
			wrEn <= 1'b0;
			fr.frameRd <= 1'b0;
			fr.meanRd <= 1'b0;
		end
		else if (clear)
		begin
			state <= cutIdle;
			stripAddr <= '0;
			wordCount <= '0;
			wrEn <= 1'b0;
			fr.frameRd <= 1'b0;
			fr.meanRd <= 1'b0;
		end
		else
		begin
			wrEn <= 1'b0;
			fr.frameRd <= 1'b0;
			fr.meanRd <= 1'b0;
			case (state)
				cutIdle:
					if (fr.frameReady)
					begin
						wrEn <= 1'b1;
						fr.frameRd <= 1'b1;
						stripAddr <= '0;
						wordCount <= wordCountWidth'(2);
						state <= cutAddr;
					end
				// Threshold read and strip pop both land during this cycle
				cutAddr:
					state <= cutCompare;
				cutCompare:
				begin
					wrEn <= keep;
					fr.frameRd <= 1'b1;
					stripAddr <= stripAddr + 1'b1;
					if (keep)
						wordCount <= wordCount + 1'b1;
					state <= (stripAddr == lastStrip) ? cutTrailerWait : cutAddr;
				end
				cutTrailerWait:
					state <= cutModuleTrailer;
				cutModuleTrailer:
				begin
					wrEn <= 1'b1;
					fr.frameRd <= 1'b1;
					state <= cutCountTrailer;
				end
				cutCountTrailer:
				begin
					wrEn <= 1'b1;
					fr.meanRd <= 1'b1;
					state <= cutDone;
				end
				// Gives the decoder a cycle to drop frameReady
				cutDone:
					state <= cutIdle;
				default:
					state <= cutIdle;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		case (state)
			cutIdle:
				wrData.header <= '{tagHeader, 1'b0, fr.mean[dataWidth-1], fr.frameData, chId};
			cutCompare:
				wrData.strip <= '{tagStrip, stripAddr, diff[dataWidth-1:0]};
			cutModuleTrailer:
				wrData.moduleTrailer <= '{tagModuleTrailer, 2'b00, moduleId,
					fr.frameData[dataWidth-1:0]};
			cutCountTrailer:
				wrData.countTrailer <= '{tagCountTrailer, fr.mean[dataWidth-2:0], wordCount};
			default:
				wrData <= wrData;
		endcase
	end

endmodule

//--- hw/outputFifo.sv
// Show-ahead FIFO, writes when full and reads when empty are dropped
`timescale 1ns/1ps

module outputFifo
	import chanPkg::*;
#(
	parameter int fifoAddrWidth = defaultFifoAddrWidth
)
(
	input logic CLK,
	input logic RSTb,
	input logic clear,
	input logic wrEn,
	input outWord wrData,
	input logic rdEn,
	output outWord rdData,
	output logic empty,
	output logic full,
	output logic [fifoAddrWidth:0] usedWords
);

	localparam int depth = 1 << fifoAddrWidth;

	outWord mem [depth];
	logic [fifoAddrWidth-1:0] wrPtr;
	logic [fifoAddrWidth-1:0] rdPtr;
	logic doWrite;
	logic doRead;

	// Count never exceeds depth, so its top bit alone flags full
	assign full = usedWords[fifoAddrWidth];
	assign empty = (usedWords == '0);
	assign doWrite = wrEn && !full;
	assign doRead = rdEn && !empty;
	assign rdData = mem[rdPtr];

	always_ff @(posedge CLK)
	begin
		if (doWrite)
			mem[wrPtr] <= wrData;
	end

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			usedWords <= '0;
		end
		else if (clear)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			usedWords <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doRead)
				rdPtr <= rdPtr + 1'b1;
			if (doWrite && !doRead)
				usedWords <= usedWords + 1'b1;
			else if (doRead && !doWrite)
				usedWords <= usedWords - 1'b1;
		end
	end

endmodule

//--- hw/eventCounter.sv
// Saturates at both ends; inc takes priority over dec in the same cycle
`timescale 1ns/1ps

module eventCounter
	import chanPkg::*;
(
	input logic CLK,
	input logic RSTb,
	input logic clear,
	input logic inc,
	input logic dec,
	output logic nonZero
);

	logic [countWidth-1:0] count;

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			count <= '0;
			nonZero <= 1'b0;
		end
		else if (clear)
		begin
			count <= '0;
			nonZero <= 1'b0;
		end
		else
		begin
			// Flag lags the count by one cycle
			nonZero <= (count != '0);
			if (inc)
			begin
				if (count != '1)
					count <= count + 1'b1;
			end
			else if (dec && count != '0)
				count <= count - 1'b1;
		end
	end

endmodule

//--- hw/channelProcessor.sv
// One channel: threshold RAM, zero suppression, output FIFO and event count
// Frames are only taken while chEnable is high; low gives host RAM access
`timescale 1ns/1ps

module channelProcessor
	import chanPkg::*;
#(
	parameter int fifoAddrWidth = defaultFifoAddrWidth
)
(
	input logic CLK,
	input logic RSTb,
	input logic allClear,
	input logic chEnable,
	input logic enableBaseSub,
	input logic [3:0] chId,
	input logic [4:0] moduleId,
	input logic [frameWidth-1:0] frameData,
	input logic frameReady,
	output logic frameRd,
	input logic [dataWidth-1:0] mean,
	output logic meanRd,
	input logic [stripAddrWidth-1:0] ramAddr,
	input logic [dataWidth-1:0] ramData,
	input logic ramWe,
	output logic [wordWidth-1:0] dataOut,
	input logic fifoRd,
	output logic fifoEmpty,
	output logic fifoFull,
	output logic [fifoAddrWidth:0] fifoUsedWords,
	input logic decrEvent,
	output logic eventPresent
);

	logic [stripAddrWidth-1:0] stripAddr;
	logic [stripAddrWidth-1:0] ramRdAddr;
	logic [dataWidth-1:0] threshold;
	logic wrEn;
	outWord wrData;
	outWord fifoHead;

	frameIf fr();

	assign fr.frameData = frameData;
	assign fr.frameReady = frameReady & chEnable;
	assign fr.mean = mean;
	assign frameRd = fr.frameRd;
	assign meanRd = fr.meanRd;

	assign ramRdAddr = chEnable ? stripAddr : ramAddr;
	assign dataOut = chEnable ? fifoHead : {{(wordWidth - dataWidth){1'b0}}, threshold};

	thresholdRam thrRam (.CLK(CLK), .we(ramWe), .wrAddr(ramAddr), .wrData(ramData),
		.rdAddr(ramRdAddr), .rdData(threshold));

	zeroSuppressor zeroSup (.CLK(CLK), .RSTb(RSTb), .clear(allClear),
		.enableBaseSub(enableBaseSub), .chId(chId), .moduleId(moduleId), .fr(fr.cut),
		.stripAddr(stripAddr), .threshold(threshold), .wrEn(wrEn), .wrData(wrData));

	outputFifo #(.fifoAddrWidth(fifoAddrWidth)) outFifo (.CLK(CLK), .RSTb(RSTb),
		.clear(allClear), .wrEn(wrEn), .wrData(wrData), .rdEn(fifoRd), .rdData(fifoHead),
		.empty(fifoEmpty), .full(fifoFull), .usedWords(fifoUsedWords));

	eventCounter evCounter (.CLK(CLK), .RSTb(RSTb), .clear(allClear), .inc(fr.meanRd),
		.dec(decrEvent), .nonZero(eventPresent));

endmodule

//--- test/channelProcessor_checker.sv
// Bound into channelProcessor; frameReady is the raw port, gated here by chEnable
`timescale 1ns/1ps

module channelProcessor_checker
	import chanPkg::*;
(
	input logic CLK,
	input logic RSTb,
	input logic fifoFull,
	input logic fifoEmpty,
	input logic meanRd,
	input logic frameRd,
	input logic frameReady,
	input logic chEnable,
	input cutState state
);

	int assertFails = 0;

	assert property (@(posedge CLK) disable iff (!RSTb) !(fifoFull && fifoEmpty))
	else
	begin
		assertFails++;
		$error("FIFO shows full and empty at once");
	end

	assert property (@(posedge CLK) disable iff (!RSTb) meanRd |=> !meanRd)
	else
	begin
		assertFails++;
		$error("meanRd held high for more than one cycle");
	end

	// No pop without a waiting frame while the cut logic is idle
	assert property (@(posedge CLK) disable iff (!RSTb)
		(state == cutIdle && !(frameReady && chEnable)) |=> !frameRd)
	else
	begin
		assertFails++;
		$error("frameRd high in idle with no frame waiting");
	end

endmodule

//--- test/channelProcessorTb.sv
// Models the frame decoder as a word queue; thresholds are loaded before every frame
// Expected words follow the zero-suppression rule with 13-bit wrapping subtraction
`timescale 1ns/1ps

module channelProcessorTb
	import chanPkg::*;
();
	localparam int rowCount = 4;
	localparam int cycleLimit = rowCount * 400 + 2000;

	typedef struct {
		logic [dataWidth-1:0] mean;
		logic sub;
		int thrMode;
		logic [frameWidth-1:0] base;
	} frameRow;

	logic CLK;
	logic RSTb;
	logic allClear;
	logic chEnable;
	logic enableBaseSub;
	logic [3:0] chId;
	logic [4:0] moduleId;
	logic [frameWidth-1:0] frameData = '0;
	logic frameReady = 1'b0;
	logic frameRd;
	logic [dataWidth-1:0] mean;
	logic meanRd;
	logic [stripAddrWidth-1:0] ramAddr;
	logic [dataWidth-1:0] ramData;
	logic ramWe;
	logic [wordWidth-1:0] dataOut;
	logic fifoRd;
	logic fifoEmpty;
	logic fifoFull;
	logic [11:0] fifoUsedWords;
	logic decrEvent;
	logic eventPresent;

	frameRow rows [rowCount];
	logic [dataWidth-1:0] thr [stripCount];
	logic [frameWidth-1:0] frameQ [$];
	logic [wordWidth-1:0] expQ [$];
	int errors = 0;
	int cycles = 0;
	int seed;

	channelProcessor #(.fifoAddrWidth(11)) UUT (.*);

	bind channelProcessor channelProcessor_checker chk (.CLK(CLK), .RSTb(RSTb),
		.fifoFull(fifoFull), .fifoEmpty(fifoEmpty), .meanRd(meanRd), .frameRd(frameRd),
		.frameReady(frameReady), .chEnable(chEnable), .state(zeroSup.state));

	initial
	begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Decoder FIFO: head word on frameData, ready once a whole frame is queued
	always @(posedge CLK)
	begin
		if (frameRd && frameQ.size() > 0)
			void'(frameQ.pop_front());
		frameData <= (frameQ.size() > 0) ? frameQ[0] : '0;
		frameReady <= (frameQ.size() >= stripCount + 2);
	end

	always @(posedge CLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit)
		begin
			$display("Timeout after %0d cycles, the DUT never finished the event", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	task checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	// Mode 0 ramp, 1 all ones (strip disabled), else random
	task loadThresholds(input int mode);
		for (int a = 0; a < stripCount; a++)
		begin
			case (mode)
				0: thr[a] = dataWidth'(a * 8);
				1: thr[a] = '1;
				default: thr[a] = dataWidth'($random(seed) & 'h1ff);
			endcase
			@(posedge CLK);
			ramWe <= 1'b1;
			ramAddr <= stripAddrWidth'(a);
			ramData <= thr[a];
		end
		@(posedge CLK);
		ramWe <= 1'b0;
	endtask

	// Pipelined readback, data for an address shows one edge after it
	task readThresholds();
		for (int a = 0; a <= stripCount; a++)
		begin
			@(posedge CLK);
			if (a < stripCount)
				ramAddr <= stripAddrWidth'(a);
			@(negedge CLK);
			if (a > 0)
				checkValue("dataOut", 32'(dataOut), 32'(thr[a-1]));
		end
	endtask

	task sendFrame(input int r);
		logic [frameWidth-1:0] strip;
		logic [frameWidth-1:0] diff;
		logic [frameWidth-1:0] hdr;
		logic [frameWidth-1:0] trailer;
		int kept;
		kept = 0;
		hdr = 13'h1000 | 13'(r);
		trailer = frameWidth'($random(seed));
		expQ.delete();
		@(negedge CLK);
		frameQ.push_back(hdr);
		for (int s = 0; s < stripCount; s++)
		begin
			strip = rows[r].base + frameWidth'($random(seed) & 'hff);
			frameQ.push_back(strip);
			diff = strip - (rows[r].sub ? {1'b0, rows[r].mean} : 13'h0);
			if (thr[s] != 12'hfff && diff > {1'b0, thr[s]})
			begin
				expQ.push_back({2'b01, 7'(s), diff[11:0]});
				kept++;
			end
		end
		frameQ.push_back(trailer);
		expQ.push_front({2'b00, 1'b0, rows[r].mean[11], hdr, chId});
		expQ.push_back({2'b10, 2'b00, moduleId, trailer[11:0]});
		expQ.push_back({2'b11, rows[r].mean[10:0], 8'(kept + 2)});
	endtask

	// meanRd ends the event; count trailer and flag settle two edges later
	task waitForEvent();
		while (meanRd !== 1'b1)
			@(negedge CLK);
		@(posedge CLK);
		@(posedge CLK);
		@(negedge CLK);
		checkValue("eventPresent", 32'(eventPresent), 32'd1);
		checkValue("fifoUsedWords", 32'(fifoUsedWords), 32'(expQ.size()));
		checkValue("fifoFull", 32'(fifoFull), 32'd0);
	endtask

	task drainFifo();
		int n;
		n = expQ.size();
		@(posedge CLK);
		fifoRd <= 1'b1;
		for (int i = 0; i < n; i++)
		begin
			@(negedge CLK);
			checkValue("dataOut", 32'(dataOut), 32'(expQ[i]));
			@(posedge CLK);
			if (i == n - 1)
				fifoRd <= 1'b0;
		end
		@(negedge CLK);
		checkValue("fifoEmpty", 32'(fifoEmpty), 32'd1);
	endtask

	task pulseDecrement();
		@(posedge CLK);
		decrEvent <= 1'b1;
		@(posedge CLK);
		decrEvent <= 1'b0;
		@(posedge CLK);
		@(negedge CLK);
	endtask

	initial
	begin
		seed = 32'hdc1fd1f1;
		rows[0] = '{12'h064, 1'b1, 0, 13'h0190};
		rows[1] = '{12'h9a0, 1'b1, 1, 13'h0a00};
		rows[2] = '{12'h7ff, 1'b0, 2, 13'h00c8};
		// Small base under the mean makes the subtraction wrap
		rows[3] = '{12'h040, 1'b1, 0, 13'h0010};
		RSTb = 1'b0;
		allClear = 1'b0;
		chEnable = 1'b0;
		enableBaseSub = 1'b0;
		chId = 4'h5;
		moduleId = 5'h13;
		mean = '0;
		ramAddr = '0;
		ramData = '0;
		ramWe = 1'b0;
		fifoRd = 1'b0;
		decrEvent = 1'b0;
		repeat (8) @(posedge CLK);
		RSTb <= 1'b1;
		@(negedge CLK);
		checkValue("fifoEmpty", 32'(fifoEmpty), 32'd1);
		checkValue("fifoFull", 32'(fifoFull), 32'd0);
		checkValue("fifoUsedWords", 32'(fifoUsedWords), 32'd0);
		checkValue("eventPresent", 32'(eventPresent), 32'd0);
		checkValue("frameRd", 32'(frameRd), 32'd0);
		checkValue("meanRd", 32'(meanRd), 32'd0);
		for (int r = 0; r < rowCount; r++)
		begin
			@(posedge CLK);
			chEnable <= 1'b0;
			loadThresholds(rows[r].thrMode);
			readThresholds();
			@(posedge CLK);
			chEnable <= 1'b1;
			mean <= rows[r].mean;
			enableBaseSub <= rows[r].sub;
			sendFrame(r);
			waitForEvent();
			drainFifo();
		end
		for (int k = 1; k <= rowCount; k++)
		begin
			pulseDecrement();
			checkValue("eventPresent", 32'(eventPresent), 32'(k < rowCount));
		end
		// One more event left in the FIFO, then a common clear
		sendFrame(rowCount - 1);
		waitForEvent();
		@(posedge CLK);
		allClear <= 1'b1;
		@(posedge CLK);
		allClear <= 1'b0;
		@(negedge CLK);
		checkValue("fifoEmpty", 32'(fifoEmpty), 32'd1);
		checkValue("fifoUsedWords", 32'(fifoUsedWords), 32'd0);
		checkValue("eventPresent", 32'(eventPresent), 32'd0);
		errors += UUT.chk.assertFails;
		$display("Run finished with %0d errors, %0d of them from assertions", errors,
			UUT.chk.assertFails);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- list.f
hw/chanPkg.sv
hw/frameIf.sv
hw/thresholdRam.sv
hw/zeroSuppressor.sv
hw/outputFifo.sv
hw/eventCounter.sv
hw/channelProcessor.sv
test/channelProcessor_checker.sv
test/channelProcessorTb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module channelProcessorTb \
	-f list.f -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "All checks passed"; then
	exit 0
fi
exit 1
